/* zx_pkg.sv */
// Shared types, enums and layout constants of the memory and port core
package zx_pkg;

	// ============================================================
	// Store layout
	// ============================================================
	localparam int PAGE_BITS     = 14;	// Offset inside a 16K page
	localparam int RAM_PAGES     = 8;
	localparam int ROM_PAGES     = 4;	// ROM r sits at flat page RAM_PAGES + r
	localparam int FLAT_BITS     = 18;
	localparam int PAGE_IDX_BITS = FLAT_BITS - PAGE_BITS;
	localparam int STORE_BYTES   = (RAM_PAGES + ROM_PAGES) << PAGE_BITS;

	// I/O decode
	localparam logic [7:0] PORT_KEMPSTON = 8'h1F;
	localparam logic [7:0] IO_IDLE_DATA  = 8'hFF;	// Undecoded read
	localparam int KEY_ROWS = 8;
	localparam int KEY_COLS = 5;

	typedef enum logic [1:0] {
		MODEL_48,
		MODEL_128,
		MODEL_PLUS3
	} zx_model_e;

	typedef enum logic [1:0] {
		BUS_IDLE,
		BUS_MEM,	// Store access, retried while the loader writes
		BUS_ACK
	} bus_state_e;

	// ============================================================
	// Bus bundles
	// ============================================================
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic        io;	// I/O space when set
		logic [15:0] adr;
		logic [7:0]  dat;
	} wb_req_t;

	typedef struct packed {
		logic       ack;
		logic [7:0] dat;
	} wb_rsp_t;

	typedef struct packed {
		logic                 wr;
		logic [FLAT_BITS-1:0] adr;
		logic [7:0]           dat;
	} ld_req_t;

	typedef struct packed {
		logic        io_wr;	// One-cycle pulses
		logic        mem_rd;
		logic        mem_wr;
		logic [15:0] adr;
		logic [7:0]  dat;
	} bus_cmd_t;

	typedef struct packed {
		zx_model_e  model;
		logic [7:0] reg_7ffd;
		logic [7:0] reg_1ffd;
		logic       locked;
	} page_state_t;

endpackage

/* zx_page_store.sv */
// Flat byte store of the RAM and ROM pages with registered read
module zx_page_store (
	input  logic                         clk_sys,
	input  logic [zx_pkg::FLAT_BITS-1:0] st_addr,
	input  logic                         st_we,
	input  logic [7:0]                   st_dat,
	output logic [7:0]                   rd_dat
);
	import zx_pkg::*;

	logic [7:0] mem [STORE_BYTES];	// 8 RAM then 4 ROM pages

	// Read returns old data on a same-cycle write
	always_ff @(posedge clk_sys) begin
		if (st_we) begin
			mem[st_addr] <= st_dat;
		end
		rd_dat <= mem[st_addr];
	end

endmodule

/* zx_addr_map.sv */
// CPU address to flat page mapping, ROM write protection and loader priority
module zx_addr_map (
	input  zx_pkg::bus_cmd_t              cmd,
	input  zx_pkg::page_state_t           page,
	input  zx_pkg::ld_req_t               ld_req,
	output logic [zx_pkg::FLAT_BITS-1:0]  st_addr,
	output logic                          st_we,
	output logic [7:0]                    st_dat
);
	import zx_pkg::*;

	logic [1:0]               slot;
	logic [1:0]               cfg;
	logic [1:0]               rom_sel;
	logic [2:0]               ram_pg;
	logic                     special;
	logic                     is_rom;
	logic [PAGE_IDX_BITS-1:0] page_idx;

	assign slot    = cmd.adr[15:14];
	assign cfg     = page.reg_1ffd[2:1];
	assign special = (page.model == MODEL_PLUS3) && page.reg_1ffd[0];	// All-RAM modes
	assign is_rom  = !special && (slot == 2'd0);

	// ROM number for slot 0
	always_comb begin
		case (page.model)
			MODEL_128:   rom_sel = {1'b0, page.reg_7ffd[4]};
			MODEL_PLUS3: rom_sel = {page.reg_1ffd[2], page.reg_7ffd[4]};
			default:     rom_sel = 2'd1;	// 48K BASIC
		endcase
	end

	// RAM page per slot
	always_comb begin
		if (special) begin
			case (slot)
				2'd0:    ram_pg = (cfg == 2'd0) ? 3'd0 : 3'd4;
				2'd1:    ram_pg = (cfg == 2'd0) ? 3'd1 : (cfg == 2'd3) ? 3'd7 : 3'd5;
				2'd2:    ram_pg = (cfg == 2'd0) ? 3'd2 : 3'd6;
				default: ram_pg = (cfg == 2'd1) ? 3'd7 : 3'd3;
			endcase
		end else begin
			case (slot)
				2'd1:    ram_pg = 3'd5;
				2'd2:    ram_pg = 3'd2;
				2'd3:    ram_pg = (page.model == MODEL_48) ? 3'd0 : page.reg_7ffd[2:0];
				default: ram_pg = 3'd0;	// Slot 0 is ROM here
			endcase
		end
	end

	assign page_idx = is_rom ? PAGE_IDX_BITS'(RAM_PAGES + rom_sel) : {1'b0, ram_pg};

	// Loader always wins the store port
	always_comb begin
		if (ld_req.wr) begin
			st_addr = ld_req.adr;
			st_we   = 1'b1;
			st_dat  = ld_req.dat;
		end else begin
			st_addr = {page_idx, cmd.adr[PAGE_BITS-1:0]};
			st_we   = cmd.mem_wr && !is_rom;	// ROM is read only
			st_dat  = cmd.dat;
		end
	end

endmodule

/* zx_io_ports.sv */
// ULA port FE output register, keyboard and Kempston read, I/O read value
module zx_io_ports (
	input  logic             clk_sys,
	input  logic             reset,
	input  zx_pkg::bus_cmd_t cmd,
	input  logic [39:0]      key_matrix,
	input  logic             ear_in,
	input  logic [4:0]       joystick,
	output logic [7:0]       io_dat,
	output logic [2:0]       border,
	output logic             ear_out,
	output logic             mic_out
);
	import zx_pkg::*;

	logic [KEY_COLS-1:0] key_bits;

	// Any even port is the ULA
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border  <= 3'd0;
			ear_out <= 1'b0;
			mic_out <= 1'b0;
		end else if (cmd.io_wr && !cmd.adr[0]) begin
			border  <= cmd.dat[2:0];
			mic_out <= cmd.dat[3];
			ear_out <= cmd.dat[4];
		end
	end

	// Rows selected by low high-address bits, keys active low
	always_comb begin
		key_bits = '1;
		for (int r = 0; r < KEY_ROWS; r++) begin
			if (!cmd.adr[8 + r]) begin
				key_bits = key_bits & key_matrix[r * KEY_COLS +: KEY_COLS];
			end
		end
	end

	always_comb begin
		if (!cmd.adr[0]) begin
			io_dat = {1'b1, ear_in, 1'b1, key_bits};
		end else if (cmd.adr[7:0] == PORT_KEMPSTON) begin
			io_dat = {3'b000, joystick};	// Kempston
		end else begin
			io_dat = IO_IDLE_DATA;
		end
	end

endmodule

/* zx_bus_ctrl.sv */
// Wishbone classic slave FSM, command pulses and read data select
module zx_bus_ctrl (
	input  logic             clk_sys,
	input  logic             reset,
	input  zx_pkg::wb_req_t  wb_req,
	output zx_pkg::wb_rsp_t  wb_rsp,
	input  logic             ld_busy,
	output zx_pkg::bus_cmd_t cmd,
	input  logic [7:0]       io_dat,
	input  logic [7:0]       mem_dat
);
	import zx_pkg::*;

	bus_state_e  state;
	logic        io_wr_q;
	logic        mem_rd_q;
	logic        mem_wr_q;
	logic        cyc_io;	// Current cycle is I/O space
	logic        ack_q;
	logic [15:0] adr_q;
	logic [7:0]  dat_q;
	logic [7:0]  rsp_dat_q;
	logic        accept;

	// Never take a new cycle while ack is still out
	assign accept = wb_req.cyc && wb_req.stb && !ack_q;

	// ============================================================
	// Control FSM
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state    <= BUS_IDLE;
			io_wr_q  <= 1'b0;
			mem_rd_q <= 1'b0;
			mem_wr_q <= 1'b0;
			cyc_io   <= 1'b0;
			ack_q    <= 1'b0;
		end else begin
			io_wr_q <= 1'b0;	// Pulses by default
			ack_q   <= 1'b0;
			case (state)
				BUS_IDLE: if (accept) begin
					io_wr_q  <= wb_req.io && wb_req.we;
					mem_rd_q <= !wb_req.io && !wb_req.we;
					mem_wr_q <= !wb_req.io && wb_req.we;
					cyc_io   <= wb_req.io;
					state    <= wb_req.io ? BUS_ACK : BUS_MEM;
				end
				BUS_MEM: if (!ld_busy) begin	// Retried while the loader holds the port
					mem_rd_q <= 1'b0;	// Access done, drop the pulses
					mem_wr_q <= 1'b0;
					state    <= BUS_ACK;
				end
				BUS_ACK: begin
					ack_q <= 1'b1;
					state <= BUS_IDLE;
				end
				default: state <= BUS_IDLE;
			endcase
		end
	end

	// Payload
	always_ff @(posedge clk_sys) begin
		if (state == BUS_IDLE && accept) begin
			adr_q <= wb_req.adr;
			dat_q <= wb_req.dat;
		end
		if (state == BUS_ACK) begin
			rsp_dat_q <= cyc_io ? io_dat : mem_dat;
		end
	end

	assign cmd    = '{io_wr: io_wr_q, mem_rd: mem_rd_q, mem_wr: mem_wr_q, adr: adr_q, dat: dat_q};
	assign wb_rsp = '{ack: ack_q, dat: rsp_dat_q};

endmodule

/* zx_page_regs.sv */
// Paging registers 7FFD and 1FFD with lock, and the machine model latch
module zx_page_regs (
	input  logic                clk_sys,
	input  logic                reset,
	input  zx_pkg::zx_model_e   model,
	input  zx_pkg::bus_cmd_t    cmd,
	output zx_pkg::page_state_t page
);
	import zx_pkg::*;

	zx_model_e  model_q;
	logic [7:0] reg_7ffd;
	logic [7:0] reg_1ffd;
	logic       locked;
	logic       dec_7ffd;
	logic       dec_1ffd;
	logic       is_plus3;

	assign is_plus3 = (model_q == MODEL_PLUS3);

	// ============================================================
	// Port decode
	// ============================================================
	// 128K style partial decode, +3 also needs A14 high
	always_comb begin
		dec_7ffd = !cmd.adr[15] && !cmd.adr[1] && (!is_plus3 || cmd.adr[14]);
		if (model_q == MODEL_48) begin
			dec_7ffd = 1'b0;	// No paging on the 48K
		end
	end

	assign dec_1ffd = is_plus3 && (cmd.adr[15:12] == 4'b0001) && !cmd.adr[1];

	// Model only moves while reset is high
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			model_q  <= model;
			reg_7ffd <= 8'h00;
			reg_1ffd <= 8'h00;
			locked   <= 1'b0;
		end else if (cmd.io_wr && !locked) begin
			if (dec_7ffd) begin
				reg_7ffd <= cmd.dat;
				locked   <= cmd.dat[5];	// Stays set until next reset
			end else if (dec_1ffd) begin
				reg_1ffd <= cmd.dat;
			end
		end
	end

	assign page = '{
		model:    model_q,
		reg_7ffd: reg_7ffd,
		reg_1ffd: reg_1ffd,
		locked:   locked
	};

endmodule

/* zx_memory_map.sv */
// Top level of the ZX Spectrum memory and port core
module zx_memory_map (
	input  logic              clk_sys,
	input  logic              reset,
	input  zx_pkg::wb_req_t   wb_req,
	output zx_pkg::wb_rsp_t   wb_rsp,
	input  zx_pkg::ld_req_t   ld_req,
	input  zx_pkg::zx_model_e model,
	input  logic [39:0]       key_matrix,
	input  logic              ear_in,
	input  logic [4:0]        joystick,
	output logic [2:0]        border,
	output logic              ear_out,
	output logic              mic_out
);
	import zx_pkg::*;

	bus_cmd_t             cmd;
	page_state_t          page;
	logic [FLAT_BITS-1:0] st_addr;
	logic                 st_we;
	logic [7:0]           st_dat;
	logic [7:0]           rd_dat;
	logic [7:0]           io_dat;

	// ============================================================
	// Bus side
	// ============================================================
	zx_bus_ctrl u_bus_ctrl (
		.clk_sys (clk_sys),
		.reset   (reset),
		.wb_req  (wb_req),
		.wb_rsp  (wb_rsp),
		.ld_busy (ld_req.wr),
		.cmd     (cmd),
		.io_dat  (io_dat),
		.mem_dat (rd_dat)
	);

	zx_page_regs u_page_regs (
		.clk_sys (clk_sys),
		.reset   (reset),
		.model   (model),
		.cmd     (cmd),
		.page    (page)
	);

	zx_io_ports u_io_ports (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cmd        (cmd),
		.key_matrix (key_matrix),
		.ear_in     (ear_in),
		.joystick   (joystick),
		.io_dat     (io_dat),
		.border     (border),
		.ear_out    (ear_out),
		.mic_out    (mic_out)
	);

	// Memory path
	zx_addr_map u_addr_map (
		.cmd     (cmd),
		.page    (page),
		.ld_req  (ld_req),
		.st_addr (st_addr),
		.st_we   (st_we),
		.st_dat  (st_dat)
	);

	zx_page_store u_page_store (
		.clk_sys (clk_sys),
		.st_addr (st_addr),
		.st_we   (st_we),
		.st_dat  (st_dat),
		.rd_dat  (rd_dat)
	);

endmodule

/* zx_memory_map_sva.sv */
// Bound assertions on the Wishbone response and the ULA border output
module zx_memory_map_sva (
	input logic            clk_sys,
	input logic            reset,
	input zx_pkg::wb_req_t wb_req,
	input zx_pkg::wb_rsp_t wb_rsp,
	input logic            io_wr,
	input logic [2:0]      border
);

	a_ack_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		wb_rsp.ack |=> !wb_rsp.ack) else $error("ack held high for more than one cycle");

	a_ack_qualified: assert property (@(posedge clk_sys) disable iff (reset)
		wb_rsp.ack |-> wb_req.cyc && wb_req.stb) else $error("ack without cyc and stb");

	a_ack_reset: assert property (@(posedge clk_sys)
		reset |=> !wb_rsp.ack) else $error("ack high during reset");

	// Ack rises on the edge after the one that takes stb
	a_io_latency: assert property (@(posedge clk_sys) disable iff (reset)
		wb_req.cyc && wb_req.stb && wb_req.io && !wb_rsp.ack
		&& !$past(wb_req.cyc && wb_req.stb && !wb_rsp.ack) |-> ##2 wb_rsp.ack)
		else $error("I/O ack not one cycle after stb");

	a_border_hold: assert property (@(posedge clk_sys) disable iff (reset)
		!io_wr |=> $stable(border)) else $error("border moved without an I/O write");

endmodule

bind zx_memory_map zx_memory_map_sva u_zx_memory_map_sva (
	.clk_sys (clk_sys),
	.reset   (reset),
	.wb_req  (wb_req),
	.wb_rsp  (wb_rsp),
	.io_wr   (cmd.io_wr),
	.border  (border)
);

/* tb_zx_memory_map.sv */
// Testbench of the memory and port core: reference map, bus tasks, shadow store and compare
module tb_zx_memory_map;
	import zx_pkg::*;

	localparam int LOADS       = 4;	// One tag load after each reset
	localparam int LOAD_BYTES  = (RAM_PAGES + ROM_PAGES) * 16;
	localparam int BUS_CYCLES  = 30 + 54 + 45 + 5 + 10;	// 128K, paging, +3, 48K, ports
	localparam int CYCLE_LIMIT = BUS_CYCLES * 4 + LOADS * LOAD_BYTES + 200;
	// +3 all-RAM pages, one octal digit per slot, slot 0 lowest
	localparam logic [47:0] SPECIAL_MAP = {12'o3674, 12'o3654, 12'o7654, 12'o3210};

	logic        clk_sys = 1'b0;
	logic        reset = 1'b1;
	wb_req_t     wb_req;
	wb_rsp_t     wb_rsp;
	ld_req_t     ld_req;
	zx_model_e   model;
	logic [39:0] key_matrix;
	logic        ear_in;
	logic [4:0]  joystick;
	logic [2:0]  border;
	logic        ear_out;
	logic        mic_out;
	integer      seed = 32'h7b41_38d5;
	int          cycle_cnt = 0;
	logic [7:0]  shadow [STORE_BYTES];	// Mirror of loader and CPU writes
	logic [7:0]  exp_q [$];	// Expected read data in bus order
	zx_model_e   m_model;
	logic [7:0]  m_7ffd;
	logic [7:0]  m_1ffd;
	logic        m_locked;
	logic [4:0]  m_fe;	// Expected ear, mic, border

	always #20 clk_sys = ~clk_sys;

	zx_memory_map u_zx_memory_map (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.wb_req     (wb_req),
		.wb_rsp     (wb_rsp),
		.ld_req     (ld_req),
		.model      (model),
		.key_matrix (key_matrix),
		.ear_in     (ear_in),
		.joystick   (joystick),
		.border     (border),
		.ear_out    (ear_out),
		.mic_out    (mic_out)
	);

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("Error: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("=== FAIL ===");
			$fatal(1, "timeout");
		end
	end

	task automatic compare_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
			$display("=== FAIL ===");
			$fatal(1, "value mismatch");
		end
	endtask

	// Each acked cycle with an entry waiting is a read
	always @(negedge clk_sys) begin
		if (!reset && wb_rsp.ack && exp_q.size() > 0) begin
			compare_byte("wb_rsp.dat", wb_rsp.dat, exp_q.pop_front());
		end
	end

	// ============================================================
	// Reference model
	// ============================================================
	function automatic logic [FLAT_BITS:0] ref_flat_addr(input zx_model_e mdl,
			input logic [7:0] r7ffd, input logic [7:0] r1ffd, input logic [15:0] adr);
		logic [1:0] slot;
		logic [3:0] pg;
		logic       rom;
		slot = adr[15:14];
		rom  = 1'b0;
		if (mdl == MODEL_PLUS3 && r1ffd[0]) begin
			pg = {1'b0, SPECIAL_MAP[r1ffd[2:1] * 12 + slot * 3 +: 3]};
		end else begin
			case (slot)
				2'd0: begin
					rom = 1'b1;
					case (mdl)
						MODEL_48:  pg = 4'd9;	// ROM 1
						MODEL_128: pg = 4'd8 + r7ffd[4];
						default:   pg = 4'd8 + {r1ffd[2], r7ffd[4]};
					endcase
				end
				2'd1:    pg = 4'd5;
				2'd2:    pg = 4'd2;
				default: pg = (mdl == MODEL_48) ? 4'd0 : {1'b0, r7ffd[2:0]};
			endcase
		end
		return {rom, pg, adr[13:0]};
	endfunction

	function automatic logic [7:0] ula_read(input logic [15:0] adr);
		logic [4:0] keys;
		keys = 5'h1F;
		for (int r = 0; r < 8; r++) begin
			if (!adr[8 + r]) begin
				keys = keys & key_matrix[r * 5 +: 5];	// Row selected by a low address bit
			end
		end
		return {1'b1, ear_in, 1'b1, keys};
	endfunction

	// ============================================================
	// Bus and loader tasks
	// ============================================================
	task automatic bus_cycle(input logic io, input logic we, input logic [15:0] adr,
			input logic [7:0] dat);
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, io: io, adr: adr, dat: dat};
		do begin
			@(posedge clk_sys);
			#1;
		end while (!wb_rsp.ack);
		@(posedge clk_sys);	// Master sees ack on this edge
		#1;
		wb_req = '0;
	endtask

	task automatic mem_write(input logic [15:0] adr, input logic [7:0] dat);
		logic [FLAT_BITS:0] fa;
		fa = ref_flat_addr(m_model, m_7ffd, m_1ffd, adr);
		if (!fa[FLAT_BITS]) begin
			shadow[fa[FLAT_BITS-1:0]] = dat;	// ROM keeps its contents
		end
		bus_cycle(1'b0, 1'b1, adr, dat);
	endtask

	task automatic mem_read(input logic [15:0] adr);
		logic [FLAT_BITS:0] fa;
		fa = ref_flat_addr(m_model, m_7ffd, m_1ffd, adr);
		exp_q.push_back(shadow[fa[FLAT_BITS-1:0]]);
		bus_cycle(1'b0, 1'b0, adr, 8'h00);
	endtask

	task automatic io_read(input logic [15:0] adr, input logic [7:0] exp);
		exp_q.push_back(exp);
		bus_cycle(1'b1, 1'b0, adr, 8'h00);
	endtask

	task automatic io_write(input logic [15:0] adr, input logic [7:0] dat);
		if (!adr[0]) begin
			m_fe = dat[4:0];
		end
		if (!m_locked && m_model != MODEL_48 && !adr[15] && !adr[1]
				&& (m_model != MODEL_PLUS3 || adr[14])) begin
			m_7ffd   = dat;
			m_locked = dat[5];
		end else if (!m_locked && m_model == MODEL_PLUS3 && adr[15:12] == 4'b0001
				&& !adr[1]) begin
			m_1ffd = dat;
		end
		bus_cycle(1'b1, 1'b1, adr, dat);
		compare_byte("border", {5'b0, border}, {5'b0, m_fe[2:0]});
		compare_byte("mic_out", {7'b0, mic_out}, {7'b0, m_fe[3]});
		compare_byte("ear_out", {7'b0, ear_out}, {7'b0, m_fe[4]});
	endtask

	task automatic rom_write_dropped();
		mem_write(16'h0005, 8'($random(seed)));
		mem_read(16'h0005);
	endtask

	// Reset with a new model, then tag the first 16 bytes of every page
	task automatic reset_and_load(input zx_model_e mdl);
		reset = 1'b1;
		model = mdl;
		repeat (10) @(posedge clk_sys);
		#1;
		reset    = 1'b0;
		model    = (mdl == MODEL_48) ? MODEL_128 : MODEL_48;	// Latched copy must hold
		m_model  = mdl;
		m_7ffd   = 8'h00;
		m_1ffd   = 8'h00;
		m_locked = 1'b0;
		m_fe     = 5'd0;
		compare_byte("border", {5'b0, border}, 8'h00);
		for (int p = 0; p < RAM_PAGES + ROM_PAGES; p++) begin
			for (int i = 0; i < 16; i++) begin
				ld_req = '{wr: 1'b1, adr: {4'(p), 14'(i)}, dat: {4'(p), 4'(i)}};
				shadow[{4'(p), 14'(i)}] = {4'(p), 4'(i)};
				@(posedge clk_sys);
				#1;
			end
		end
		ld_req = '0;
	endtask

	initial begin
		wb_req     = '0;
		ld_req     = '0;
		model      = MODEL_128;
		key_matrix = '1;
		ear_in     = 1'b0;
		joystick   = 5'd0;

		// 128K map and RAM slots
		reset_and_load(MODEL_128);
		for (int s = 0; s < 4; s++) begin
			mem_read({2'(s), 14'h0003});
		end
		for (int s = 1; s < 4; s++) begin
			for (int i = 0; i < 4; i++) begin
				mem_write({2'(s), 14'h0100 + 14'(i * 37)}, 8'($random(seed)));
				mem_read({2'(s), 14'h0100 + 14'(i * 37)});
			end
		end
		rom_write_dropped();

		// 7FFD switching, page contents kept, then lock
		for (int p = 0; p < 8; p++) begin
			io_write(16'h7FFD, {3'b000, p[0], 1'b0, 3'(p)});
			mem_write(16'hC200 + 16'(p), 8'($random(seed)));
			mem_read(16'h0001);
			mem_read(16'hC001);
		end
		for (int p = 0; p < 8; p++) begin
			io_write(16'h7FFD, {5'b00000, 3'(p)});
			mem_read(16'hC200 + 16'(p));
		end
		io_write(16'h7FFD, 8'h23);	// Page 3, locked
		io_write(16'h7FFD, 8'h16);
		mem_read(16'h0002);
		mem_read(16'hC002);
		reset_and_load(MODEL_128);
		io_write(16'h7FFD, 8'h06);
		mem_read(16'hC004);

		// ============================================================
		// +3 ROM select and all-RAM configurations
		// ============================================================
		reset_and_load(MODEL_PLUS3);
		for (int r = 0; r < 4; r++) begin
			io_write(16'h1FFD, {5'b00000, r[1], 2'b00});
			io_write(16'h7FFD, {3'b000, r[0], 4'h0});
			mem_read(16'h0006);
		end
		io_write(16'h3FFD, 8'h07);	// A14 low, no 7FFD decode on the +3
		mem_read(16'hC006);
		for (int c = 0; c < 4; c++) begin
			io_write(16'h1FFD, {5'b00000, 2'(c), 1'b1});
			for (int s = 0; s < 4; s++) begin
				mem_read({2'(s), 14'h0007});
			end
			mem_write(16'h0300 + 16'(c), 8'($random(seed)));
			mem_read(16'h0300 + 16'(c));
		end
		io_write(16'h1FFD, 8'h00);
		rom_write_dropped();

		// 48K ignores paging
		reset_and_load(MODEL_48);
		io_write(16'h7FFD, 8'h17);
		mem_read(16'h0008);
		mem_read(16'hC008);
		rom_write_dropped();

		// ULA and Kempston ports
		io_write(16'h00FE, 8'h1D);
		io_write(16'h00FE, 8'h0A);
		key_matrix = {8'($random(seed)), 32'($random(seed))};
		ear_in     = 1'b1;
		joystick   = 5'h15;
		io_read(16'hFEFE, ula_read(16'hFEFE));
		io_read(16'h7FFE, ula_read(16'h7FFE));
		io_read(16'hBDFE, ula_read(16'hBDFE));
		io_read(16'h00FE, ula_read(16'h00FE));
		io_read(16'hFFFE, ula_read(16'hFFFE));
		io_read(16'h001F, {3'b000, joystick});
		io_read(16'h00FF, 8'hFF);
		io_read(16'h123F, 8'hFF);

		$display("=== PASS ===");
		$finish;
	end

endmodule

/* files.f */
zx_pkg.sv
zx_page_store.sv
zx_addr_map.sv
zx_io_ports.sv
zx_bus_ctrl.sv
zx_page_regs.sv
zx_memory_map.sv
zx_memory_map_sva.sv
tb_zx_memory_map.sv

/* Bender.yml */
package:
  name: zx_memory_map

sources:
  - zx_pkg.sv
  - zx_page_store.sv
  - zx_addr_map.sv
  - zx_io_ports.sv
  - zx_bus_ctrl.sv
  - zx_page_regs.sv
  - zx_memory_map.sv
  - target: test
    files:
      - zx_memory_map_sva.sv
      - tb_zx_memory_map.sv
